// ==== all.f ====
+incdir+rtl
rtl/l2_pkg.sv
rtl/tag_store.sv
rtl/lru_tracker.sv
rtl/cache_fsm.sv
rtl/l2_cache_ctrl.sv
verif/l2_cache_ctrl_tb.sv

// ==== rtl/cache_fsm.sv ====
`timescale 1ns/100ps
`include "l2_consts.svh"

module cache_fsm import l2_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  l1_req_t   l1_req,
    input  logic      flush,
    input  logic      mem_ready,
    input  set_view_t set_view,
    input  way_t      oldest_way,
    output fill_cmd_t fill_cmd,
    output touch_t    touch,
    output mem_req_t  mem_req,
    output logic      flush_idle,
    output logic      ready,
    output logic      update,
    output logic      refill,
    output logic      miss,
    output way_t      way
);

    state_t state;
    state_t next_state;
    way_t   victim;
    logic   victim_dirty;
    logic   req_present;

    assign req_present = l1_req.read || l1_req.write;

    // hit way, then lowest free way, then lru
    always_comb
    begin
        if (set_view.hit)
            victim = set_view.hit_way;
        else if (set_view.has_invalid)
            victim = set_view.first_invalid_way;
        else
            victim = oldest_way;
    end

    assign victim_dirty = set_view.valid[victim] && set_view.dirty[victim];

    always_comb
    begin
        next_state = state;
        unique case (state)
            idle:
            begin
                // ready high means the request was just served
                if (req_present && !ready)
                    next_state = compare;
            end
            compare:
            begin
                if (set_view.hit)
                    next_state = idle;
                else if (victim_dirty)
                    next_state = write_back;
                else
                    next_state = allocate;
            end
            write_back:
            begin
                if (mem_ready)
                    next_state = allocate;
            end
            allocate:
            begin
                if (mem_ready)
                    next_state = compare;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state  <= idle;
            way    <= '0;
            ready  <= 1'b0;
            update <= 1'b0;
            refill <= 1'b0;
            miss   <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            ready  <= (state == compare) && set_view.hit;
            update <= (state == compare) && set_view.hit && l1_req.write;
            miss   <= (state == compare) && !set_view.hit;
            refill <= (state == allocate) && mem_ready;
            if (state == compare)
                way <= victim;
        end
    end

    assign mem_req.read      = (state == allocate);
    assign mem_req.write     = (state == write_back);
    assign mem_req.tag       = l1_req.tag;
    assign mem_req.index     = l1_req.index;
    assign mem_req.write_tag = set_view.tags[way];

    assign fill_cmd.fill       = (state == allocate) && mem_ready;
    assign fill_cmd.mark_dirty = (state == compare) && set_view.hit && l1_req.write;
    assign fill_cmd.way        = (state == allocate) ? way : set_view.hit_way;

    assign touch.en  = (state == compare) && set_view.hit;
    assign touch.way = set_view.hit_way;

    assign flush_idle = flush && (state == idle);

    mem_rw_excl: assert property (
        @(posedge clk) disable iff (!nrst)
        !(mem_req.read && mem_req.write)
    );

    ready_miss_excl: assert property (
        @(posedge clk) disable iff (!nrst)
        !(ready && miss)
    );

endmodule

// ==== rtl/l2_cache_ctrl.sv ====
`timescale 1ns/100ps

module l2_cache_ctrl import l2_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  l1_req_t  l1_req,
    input  logic     flush,
    input  logic     mem_ready,
    output logic     ready,
    output logic     update,
    output logic     refill,
    output logic     miss,
    output way_t     way,
    output mem_req_t mem_req
);

    set_view_t set_view;
    fill_cmd_t fill_cmd;
    touch_t    touch;
    way_t      oldest_way;
    logic      flush_idle;

    tag_store tag_store_i (
        .clk      (clk),
        .nrst     (nrst),
        .index    (l1_req.index),
        .tag      (l1_req.tag),
        .fill_cmd (fill_cmd),
        .flush    (flush_idle),
        .set_view (set_view)
    );

    lru_tracker lru_tracker_i (
        .clk        (clk),
        .nrst       (nrst),
        .index      (l1_req.index),
        .touch      (touch),
        .oldest_way (oldest_way)
    );

    cache_fsm cache_fsm_i (
        .clk        (clk),
        .nrst       (nrst),
        .l1_req     (l1_req),
        .flush      (flush),
        .mem_ready  (mem_ready),
        .set_view   (set_view),
        .oldest_way (oldest_way),
        .fill_cmd   (fill_cmd),
        .touch      (touch),
        .mem_req    (mem_req),
        .flush_idle (flush_idle),
        .ready      (ready),
        .update     (update),
        .refill     (refill),
        .miss       (miss),
        .way        (way)
    );

endmodule

// ==== rtl/l2_consts.svh ====
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// address split
`define L2_TAG_W    22
`define L2_INDEX_W  4

// cache geometry
`define L2_SETS     16
`define L2_WAYS     4
`define L2_WAY_W    2

// lru age per way, 0 newest
`define L2_AGE_W    2

`endif

// ==== rtl/l2_pkg.sv ====
`include "l2_consts.svh"

package l2_pkg;

    typedef logic [`L2_TAG_W-1:0]   tag_t;
    typedef logic [`L2_INDEX_W-1:0] index_t;
    typedef logic [`L2_WAY_W-1:0]   way_t;
    typedef logic [`L2_AGE_W-1:0]   age_t;

    typedef enum logic [1:0] {
        idle       = 2'b00,
        compare    = 2'b01,
        write_back = 2'b10,
        allocate   = 2'b11
    } state_t;

    typedef struct packed {
        logic   read;
        logic   write;
        tag_t   tag;
        index_t index;
    } l1_req_t;

    typedef struct packed {
        logic   read;
        logic   write;
        tag_t   tag;
        index_t index;
        tag_t   write_tag;
    } mem_req_t;

    // addressed set plus lookup results
    typedef struct packed {
        logic [`L2_WAYS-1:0] valid;
        logic [`L2_WAYS-1:0] dirty;
        tag_t [`L2_WAYS-1:0] tags;
        logic                hit;
        way_t                hit_way;
        logic                has_invalid;
        way_t                first_invalid_way;
    } set_view_t;

    typedef struct packed {
        logic fill;
        logic mark_dirty;
        way_t way;
    } fill_cmd_t;

    typedef struct packed {
        logic en;
        way_t way;
    } touch_t;

endpackage

// ==== rtl/lru_tracker.sv ====
`timescale 1ns/100ps
`include "l2_consts.svh"

module lru_tracker import l2_pkg::*;
(
    input  logic   clk,
    input  logic   nrst,
    input  index_t index,
    input  touch_t touch,
    output way_t   oldest_way
);

    age_t ages [`L2_SETS][`L2_WAYS];
    age_t touched_age;

    assign touched_age = ages[index][touch.way];

    // touched way becomes newest, younger ways age by one
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
                for (int w = 0; w < `L2_WAYS; w++)
                    ages[s][w] <= age_t'(w);
        end
        else if (touch.en)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                if (way_t'(w) == touch.way)
                    ages[index][w] <= '0;
                else if (ages[index][w] < touched_age)
                    ages[index][w] <= ages[index][w] + age_t'(1);
            end
        end
    end

    always_comb
    begin
        oldest_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (ages[index][w] == age_t'(`L2_WAYS - 1))
                oldest_way = way_t'(w);
        end
    end

    // ages in a set stay a permutation of 0..3
    ages_distinct: assert property (
        @(posedge clk) disable iff (!nrst)
        touch.en |-> (ages[index][0] != ages[index][1]) &&
                     (ages[index][0] != ages[index][2]) &&
                     (ages[index][0] != ages[index][3]) &&
                     (ages[index][1] != ages[index][2]) &&
                     (ages[index][1] != ages[index][3]) &&
                     (ages[index][2] != ages[index][3])
    );

endmodule

// ==== rtl/tag_store.sv ====
`timescale 1ns/100ps
`include "l2_consts.svh"

module tag_store import l2_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  index_t    index,
    input  tag_t      tag,
    input  fill_cmd_t fill_cmd,
    input  logic      flush,
    output set_view_t set_view
);

    tag_t                              tags [`L2_SETS][`L2_WAYS];
    logic [`L2_SETS-1:0][`L2_WAYS-1:0] valid;
    logic [`L2_SETS-1:0][`L2_WAYS-1:0] dirty;
    logic [`L2_WAYS-1:0]               match;

    // tag array, written only on refill
    always_ff @(posedge clk)
    begin
        if (fill_cmd.fill)
            tags[index][fill_cmd.way] <= tag;
    end

    // flush drops valid but leaves dirty alone
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            valid <= '0;
        else if (flush)
            valid <= '0;
        else if (fill_cmd.fill)
            valid[index][fill_cmd.way] <= 1'b1;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            dirty <= '0;
        else if (fill_cmd.fill)
            dirty[index][fill_cmd.way] <= 1'b0;
        else if (fill_cmd.mark_dirty)
            dirty[index][fill_cmd.way] <= 1'b1;
    end

    always_comb
    begin
        set_view.valid             = valid[index];
        set_view.dirty             = dirty[index];
        set_view.hit               = 1'b0;
        set_view.hit_way           = '0;
        set_view.has_invalid       = 1'b0;
        set_view.first_invalid_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            set_view.tags[w] = tags[index][w];
            match[w]         = valid[index][w] && (tags[index][w] == tag);
        end
        // scan from the top so the lowest way wins
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (match[w])
            begin
                set_view.hit     = 1'b1;
                set_view.hit_way = way_t'(w);
            end
            if (!valid[index][w])
            begin
                set_view.has_invalid       = 1'b1;
                set_view.first_invalid_way = way_t'(w);
            end
        end
    end

    // refill and write hit come from different fsm states
    fill_dirty_excl: assert property (
        @(posedge clk) disable iff (!nrst)
        !(fill_cmd.fill && fill_cmd.mark_dirty)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, exit status carries the result
verilator --binary --timing --assert -f all.f --top-module l2_cache_ctrl_tb -o sim \
    && ./obj_dir/sim \
    || exit 1

// ==== verif/l2_cache_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "l2_consts.svh"

module l2_cache_ctrl_tb import l2_pkg::*;
();

    localparam logic [1:0] OP_RD = 2'd0;
    localparam logic [1:0] OP_WR = 2'd1;
    localparam logic [1:0] OP_FL = 2'd2;
    localparam int NUM_TESTS = 17;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 24 + RESET_CYCLES;

    typedef struct packed {
        logic [1:0] op;
        index_t     index;
        tag_t       tag;
    } stim_t;

    logic     clk;
    logic     nrst;
    l1_req_t  l1_req;
    logic     flush;
    logic     mem_ready;
    logic     ready;
    logic     update;
    logic     refill;
    logic     miss;
    way_t     way;
    mem_req_t mem_req;

    // reference model of the cache state
    logic m_valid [`L2_SETS][`L2_WAYS];
    logic m_dirty [`L2_SETS][`L2_WAYS];
    tag_t m_tag   [`L2_SETS][`L2_WAYS];
    int   m_age   [`L2_SETS][`L2_WAYS];

    logic        exp_hit;
    logic        exp_wb;
    tag_t        exp_wb_tag;
    int          exp_way;
    logic [31:0] rand_state = 32'h81677d0f;
    int          cycles = 0;

    string test_name [NUM_TESTS] = '{
        "cold_read", "repeat_read", "write_hit", "fill_way1", "fill_way2",
        "fill_way3", "hit_way1", "evict_dirty", "evict_clean", "hit_refilled",
        "write_miss", "other_set", "flush_all", "reread_dirty", "reread_set3",
        "hit_after_flush", "refill_way1"
    };

    stim_t stim [NUM_TESTS] = '{
        '{OP_RD, 4'd3, 22'h00a5a5}, '{OP_RD, 4'd3, 22'h00a5a5}, '{OP_WR, 4'd3, 22'h00a5a5},
        '{OP_RD, 4'd3, 22'h1b0001}, '{OP_RD, 4'd3, 22'h2c0002}, '{OP_RD, 4'd3, 22'h3d0003},
        '{OP_RD, 4'd3, 22'h1b0001}, '{OP_RD, 4'd3, 22'h0e0004}, '{OP_RD, 4'd3, 22'h1f0005},
        '{OP_RD, 4'd3, 22'h0e0004}, '{OP_WR, 4'd5, 22'h200006}, '{OP_RD, 4'd9, 22'h00a5a5},
        '{OP_FL, 4'd0, 22'h000000}, '{OP_RD, 4'd5, 22'h200006}, '{OP_RD, 4'd3, 22'h1b0001},
        '{OP_RD, 4'd3, 22'h1b0001}, '{OP_RD, 4'd3, 22'h3d0003}
    };

    l2_cache_ctrl l2_cache_ctrl_i (
        .clk       (clk),
        .nrst      (nrst),
        .l1_req    (l1_req),
        .flush     (flush),
        .mem_ready (mem_ready),
        .ready     (ready),
        .update    (update),
        .refill    (refill),
        .miss      (miss),
        .way       (way),
        .mem_req   (mem_req)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                $display("timeout, the DUT stopped answering after %0d cycles", cycles);
                $display("TESTS FAILED");
                $fatal(1);
            end
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory answers each level with a pulse 1 to 4 cycles later
    initial
    begin
        int delay;
        mem_ready = 1'b0;
        forever
        begin
            @(negedge clk);
            if (mem_req.read || mem_req.write)
            begin
                rand_state = lcg_step(rand_state);
                delay = 1 + int'(rand_state[17:16]);
                repeat (delay - 1) @(negedge clk);
                mem_ready = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("error %s expected %0h actual %0h", what, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic init_model();
        for (int s = 0; s < `L2_SETS; s++)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_age[s][w]   = w;
            end
        end
    endtask

    // hit way, else lowest invalid, else age 3; then the access touches that way
    task automatic predict_access(input index_t idx, input tag_t t, input logic wr);
        int sel;
        int a;
        sel = -1;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (m_valid[idx][w] && m_tag[idx][w] == t)
                sel = w;
        end
        exp_hit    = (sel >= 0);
        exp_wb     = 1'b0;
        exp_wb_tag = '0;
        if (!exp_hit)
        begin
            for (int w = `L2_WAYS - 1; w >= 0; w--)
            begin
                if (!m_valid[idx][w])
                    sel = w;
            end
            if (sel < 0)
            begin
                for (int w = 0; w < `L2_WAYS; w++)
                begin
                    if (m_age[idx][w] == `L2_WAYS - 1)
                        sel = w;
                end
            end
            exp_wb          = m_valid[idx][sel] && m_dirty[idx][sel];
            exp_wb_tag      = m_tag[idx][sel];
            m_tag[idx][sel]   = t;
            m_valid[idx][sel] = 1'b1;
            m_dirty[idx][sel] = 1'b0;
        end
        exp_way = sel;
        a = m_age[idx][sel];
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (w == sel)
                m_age[idx][w] = 0;
            else if (m_age[idx][w] < a)
                m_age[idx][w] = m_age[idx][w] + 1;
        end
        if (wr)
            m_dirty[idx][sel] = 1'b1;
    endtask

    task automatic run_request(input string name, input stim_t s);
        logic saw_miss;
        logic saw_wb;
        logic saw_rd;
        logic saw_refill;
        logic early_update;
        tag_t wb_tag_seen;
        int   lat;
        saw_miss     = 1'b0;
        saw_wb       = 1'b0;
        saw_rd       = 1'b0;
        saw_refill   = 1'b0;
        early_update = 1'b0;
        wb_tag_seen  = '0;
        lat          = 0;
        predict_access(s.index, s.tag, s.op == OP_WR);
        l1_req.read  = (s.op == OP_RD);
        l1_req.write = (s.op == OP_WR);
        l1_req.tag   = s.tag;
        l1_req.index = s.index;
        // outputs are sampled on the falling edge, between updates
        do
        begin
            @(negedge clk);
            lat++;
            if (miss && !saw_miss)
                check_value({name, " miss way"}, 32'(exp_way), 32'(way));
            if (mem_req.write && !saw_wb)
                wb_tag_seen = mem_req.write_tag;
            if (mem_req.read && !saw_rd)
            begin
                check_value({name, " mem tag"}, 32'(s.tag), 32'(mem_req.tag));
                check_value({name, " mem index"}, 32'(s.index), 32'(mem_req.index));
            end
            saw_miss   = saw_miss | miss;
            saw_wb     = saw_wb | mem_req.write;
            saw_rd     = saw_rd | mem_req.read;
            saw_refill = saw_refill | refill;
            if (update && !ready)
                early_update = 1'b1;
        end
        while (!ready);
        check_value({name, " update"}, 32'(s.op == OP_WR), 32'(update));
        check_value({name, " update off ready"}, 32'(0), 32'(early_update));
        l1_req = '0;
        check_value({name, " miss"}, 32'(!exp_hit), 32'(saw_miss));
        check_value({name, " write-back"}, 32'(exp_wb), 32'(saw_wb));
        if (exp_wb)
            check_value({name, " write_tag"}, 32'(exp_wb_tag), 32'(wb_tag_seen));
        check_value({name, " mem read"}, 32'(!exp_hit), 32'(saw_rd));
        check_value({name, " refill"}, 32'(!exp_hit), 32'(saw_refill));
        check_value({name, " way"}, 32'(exp_way), 32'(way));
        if (exp_hit)
            check_value({name, " hit latency"}, 32'(2), 32'(lat));
    endtask

    task automatic do_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int s = 0; s < `L2_SETS; s++)
            for (int w = 0; w < `L2_WAYS; w++)
                m_valid[s][w] = 1'b0;
    endtask

    initial
    begin
        nrst   = 1'b0;
        l1_req = '0;
        flush  = 1'b0;
        init_model();
        repeat (RESET_CYCLES) @(negedge clk);
        nrst = 1'b1;
        // reset values, before any clock edge can update them
        check_value("reset strobes", 32'(0),
                    32'({ready, update, refill, miss, mem_req.read, mem_req.write}));
        @(negedge clk);
        for (int n = 0; n < NUM_TESTS; n++)
        begin
            if (stim[n].op == OP_FL)
                do_flush();
            else
                run_request(test_name[n], stim[n]);
            @(negedge clk);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule
